// ==== rankPkg.sv ====
package rankPkg;

    // ----------------------------------------
    // Timing, in controller clock cycles
    // ----------------------------------------
    localparam int tRCD     = 4;    // ACT to RD/WR
    localparam int tRP      = 3;    // PRE to ACT
    localparam int tWR      = 5;    // Write recovery before auto-precharge
    localparam int tRFC     = 12;   // REF to next command
    localparam int NumBanks = 16;   // 4 bank groups x 4 banks

    // ----------------------------------------
    // Address and counter vectors
    // ----------------------------------------
    typedef logic [3:0]  bankIdxT;  // {bank group, bank}
    typedef logic [1:0]  bgT;
    typedef logic [1:0]  bkT;
    typedef logic [14:0] rowT;
    typedef logic [9:0]  colT;
    typedef logic [17:0] cmdAddrT;  // A17..A0
    typedef logic [4:0]  timerT;    // Holds tRFC and tWR+tRP

    // Controller states
    typedef enum logic [2:0] {
        Idle,
        Precharge,
        Activate,
        Read,
        Write,
        Refresh,
        WaitTimer                   // Row or refresh window running
    } ctrlStateT;

    // Command going out on the pins this cycle
    typedef enum logic [2:0] {
        CmdNop,                     // Deselect
        CmdAct,
        CmdPre,
        CmdRd,
        CmdWr,
        CmdRef
    } cmdT;

endpackage

// ==== rowTimer.sv ====
module rowTimer import rankPkg::*; (
    input  logic  clk,
    input  logic  rst,
    input  logic  timerLoad,    // Strobe in the command issue cycle
    input  timerT timerValue,   // Cycles to spend in WaitTimer
    output logic  timeUp
);

    timerT count;

    // Loaded one short so timeUp lands in the last wait cycle
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            count <= '0;
        end else if (timerLoad) begin
            count <= timerValue - timerT'(1);
        end else if (count != '0) begin
            count <= count - timerT'(1);    // Stops at zero
        end
    end

    // A fresh load hides the old expiry
    assign timeUp = (count == '0) && !timerLoad;

endmodule

// ==== bankBusyTracker.sv ====
module bankBusyTracker import rankPkg::*; (
    input  logic    clk,
    input  logic    rst,
    input  logic    apStart,    // RD/WR with auto-precharge issued
    input  logic    apWrite,    // Write needs recovery before precharge
    input  bankIdxT apBank,
    input  bankIdxT queryBank,  // Bank of the request in flight
    output logic    bankBusy,
    output logic    anyBusy
);

    timerT               apCount [NumBanks];
    logic [NumBanks-1:0] busyVec;

    // ----------------------------------------
    // One auto-precharge countdown per bank
    // ----------------------------------------
    for (genvar i = 0; i < NumBanks; i++) begin : gBank
        always_ff @(posedge clk or negedge rst) begin
            if (!rst) begin
                apCount[i] <= '0;
            end else if (apStart && (apBank == bankIdxT'(i))) begin
                if (apWrite) begin
                    apCount[i] <= timerT'(tWR + tRP);   // Recovery, then precharge
                end else begin
                    apCount[i] <= timerT'(tRP);         // Precharge only
                end
            end else if (apCount[i] != '0) begin
                apCount[i] <= apCount[i] - timerT'(1);
            end
        end

        assign busyVec[i] = (apCount[i] != '0);
    end

    assign bankBusy = busyVec[queryBank];   // Gates PRE/ACT/RD/WR
    assign anyBusy  = |busyVec;             // REF waits for every bank

endmodule

// ==== ddrCmdEncoder.sv ====
module ddrCmdEncoder import rankPkg::*; (
    input  cmdT     cmdIssue,
    input  bankIdxT bank,
    input  rowT     row,
    input  colT     col,
    input  logic    autoPre,
    output logic    csN,
    output logic    actN,
    output cmdAddrT pinA,
    output bgT      bg,
    output bkT      b
);

    always_comb begin
        // Deselect unless a command goes out
        csN  = 1'b1;
        actN = 1'b1;
        pinA = '0;
        bg   = '0;
        b    = '0;

        unique case (cmdIssue)
            CmdAct: begin
                csN  = 1'b0;
                actN = 1'b0;                // ACT is flagged by actN alone
                pinA = cmdAddrT'(row);      // Row takes A14..A0
                bg   = bank[3:2];
                b    = bank[1:0];
            end
            CmdPre: begin
                csN      = 1'b0;
                pinA[16] = 1'b0;            // RAS
                pinA[15] = 1'b1;            // CAS
                pinA[14] = 1'b0;            // WE
                pinA[10] = 1'b0;            // Single bank
                bg       = bank[3:2];
                b        = bank[1:0];
            end
            CmdRd, CmdWr: begin
                csN      = 1'b0;
                pinA     = cmdAddrT'(col);  // Column on A9..A0
                pinA[16] = 1'b1;
                pinA[15] = 1'b0;
                pinA[14] = (cmdIssue == CmdRd); // WE high for read
                pinA[10] = autoPre;         // AP bit
                bg       = bank[3:2];
                b        = bank[1:0];
            end
            CmdRef: begin
                csN      = 1'b0;
                pinA[16] = 1'b0;
                pinA[15] = 1'b0;
                pinA[14] = 1'b1;            // All banks, no address
            end
            default: begin
            end
        endcase
    end

endmodule

// ==== rankCtrl.sv ====
module rankCtrl import rankPkg::*; (
    input  logic    clk,
    input  logic    rst,
    input  logic    reqValid,
    input  logic    reqWrite,
    input  logic    reqPageMiss,
    input  logic    reqPageEmpty,
    input  logic    reqAutoPre,
    input  logic    refresh,
    input  bankIdxT reqBank,
    input  rowT     reqRow,
    input  colT     reqCol,
    input  logic    cmdAvailable,   // CMD bus granted
    input  logic    dqAvailable,    // DQ bus ready, RD/WR only
    input  logic    timeUp,
    input  logic    bankBusy,
    input  logic    anyBusy,
    output logic    idle,
    output cmdT     cmdIssue,
    output bankIdxT curBank,
    output rowT     curRow,
    output colT     curCol,
    output logic    curAutoPre,
    output logic    timerLoad,
    output timerT   timerValue,
    output logic    apStart,
    output logic    apWrite
);

    ctrlStateT state;
    ctrlStateT stateNext;
    ctrlStateT prevState;           // Command state that started the wait
    logic      curWrite;

    // ----------------------------------------
    // Request latch
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (idle && reqValid && !refresh) begin
            curBank    <= reqBank;
            curRow     <= reqRow;
            curCol     <= reqCol;
            curAutoPre <= reqAutoPre;
            curWrite   <= reqWrite;
        end
    end

    // ----------------------------------------
    // State registers
    // ----------------------------------------
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state     <= Idle;
            prevState <= Idle;
            idle      <= 1'b0;              // Comes up one edge after reset
        end else begin
            state <= stateNext;
            idle  <= (stateNext == Idle);
            if (state != WaitTimer) begin
                prevState <= state;         // Held for the whole wait
            end
        end
    end

    // Next state and command issue
    always_comb begin
        stateNext  = state;
        cmdIssue   = CmdNop;
        timerLoad  = 1'b0;
        timerValue = '0;
        apStart    = 1'b0;
        apWrite    = 1'b0;

        unique case (state)
            Idle: begin
                if (idle && refresh) begin
                    stateNext = Refresh;    // Refresh wins over a request
                end else if (idle && reqValid) begin
                    if (reqPageMiss) begin
                        stateNext = Precharge;
                    end else if (reqPageEmpty) begin
                        stateNext = Activate;
                    end else begin
                        stateNext = reqWrite ? Write : Read;    // Page hit
                    end
                end
            end
            Precharge: begin
                if (cmdAvailable && !bankBusy) begin
                    cmdIssue   = CmdPre;
                    timerLoad  = 1'b1;
                    timerValue = timerT'(tRP - 1);  // Issue cycle counts as one
                    stateNext  = WaitTimer;
                end
            end
            Activate: begin
                if (cmdAvailable && !bankBusy) begin
                    cmdIssue   = CmdAct;
                    timerLoad  = 1'b1;
                    timerValue = timerT'(tRCD - 1);
                    stateNext  = WaitTimer;
                end
            end
            Read, Write: begin
                if (cmdAvailable && dqAvailable && !bankBusy) begin
                    cmdIssue  = (state == Write) ? CmdWr : CmdRd;
                    apStart   = curAutoPre;     // Bank closes by itself
                    apWrite   = (state == Write);
                    stateNext = Idle;
                end
            end
            Refresh: begin
                if (cmdAvailable && !anyBusy) begin
                    cmdIssue   = CmdRef;
                    timerLoad  = 1'b1;
                    timerValue = timerT'(tRFC - 1);
                    stateNext  = WaitTimer;
                end
            end
            WaitTimer: begin
                if (timeUp) begin
                    case (prevState)
                        Precharge: stateNext = Activate;
                        Activate:  stateNext = curWrite ? Write : Read;
                        default:   stateNext = Idle;    // After REF
                    endcase
                end
            end
            default: begin
                stateNext = Idle;
            end
        endcase
    end

endmodule

// ==== rankExec.sv ====
module rankExec import rankPkg::*; (
    input  logic    clk,
    input  logic    rst,
    input  logic    reqValid,
    input  logic    reqWrite,
    input  logic    reqPageMiss,
    input  logic    reqPageEmpty,
    input  logic    reqAutoPre,
    input  bankIdxT reqBank,
    input  rowT     reqRow,
    input  colT     reqCol,
    input  logic    refresh,
    input  logic    cmdAvailable,
    input  logic    dqAvailable,
    output logic    idle,
    output logic    csN,
    output logic    actN,
    output cmdAddrT pinA,
    output bgT      bg,
    output bkT      b
);

    cmdT     cmdIssue;
    bankIdxT curBank;
    rowT     curRow;
    colT     curCol;
    logic    curAutoPre;
    logic    timerLoad;
    timerT   timerValue;
    logic    timeUp;
    logic    apStart;
    logic    apWrite;
    logic    bankBusy;
    logic    anyBusy;

    rankCtrl rankCtrl_inst (
        .clk(clk), .rst(rst),
        .reqValid(reqValid), .reqWrite(reqWrite), .reqPageMiss(reqPageMiss),
        .reqPageEmpty(reqPageEmpty), .reqAutoPre(reqAutoPre), .refresh(refresh),
        .reqBank(reqBank), .reqRow(reqRow), .reqCol(reqCol),
        .cmdAvailable(cmdAvailable), .dqAvailable(dqAvailable),
        .timeUp(timeUp), .bankBusy(bankBusy), .anyBusy(anyBusy),
        .idle(idle), .cmdIssue(cmdIssue),
        .curBank(curBank), .curRow(curRow), .curCol(curCol), .curAutoPre(curAutoPre),
        .timerLoad(timerLoad), .timerValue(timerValue),
        .apStart(apStart), .apWrite(apWrite)
    );

    rowTimer rowTimer_inst (
        .clk(clk), .rst(rst),
        .timerLoad(timerLoad), .timerValue(timerValue), .timeUp(timeUp)
    );

    // Same bank starts and queries the countdown
    bankBusyTracker bankBusyTracker_inst (
        .clk(clk), .rst(rst),
        .apStart(apStart), .apWrite(apWrite), .apBank(curBank),
        .queryBank(curBank), .bankBusy(bankBusy), .anyBusy(anyBusy)
    );

    ddrCmdEncoder ddrCmdEncoder_inst (
        .cmdIssue(cmdIssue), .bank(curBank), .row(curRow), .col(curCol),
        .autoPre(curAutoPre),
        .csN(csN), .actN(actN), .pinA(pinA), .bg(bg), .b(b)
    );

endmodule

// ==== rankExecProps.sv ====
module rankExecProps import rankPkg::*; (
    input logic clk,
    input logic rst,
    input cmdT  cmdIssue,
    input logic csN
);

    logic [4:0] sincePre;   // Cycles since the last PRE, saturating
    logic [4:0] sinceAct;   // Cycles since the last ACT, saturating

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            sincePre <= '1;
            sinceAct <= '1;
        end else begin
            if (cmdIssue == CmdPre) begin
                sincePre <= 5'd1;
            end else if (sincePre != '1) begin
                sincePre <= sincePre + 5'd1;
            end
            if (cmdIssue == CmdAct) begin
                sinceAct <= 5'd1;
            end else if (sinceAct != '1) begin
                sinceAct <= sinceAct + 5'd1;
            end
        end
    end

    // Deselect whenever nothing goes out
    assert property (@(posedge clk) disable iff (!rst) (cmdIssue == CmdNop) |-> csN)
        else $error("csN low with no command issued");

    assert property (@(posedge clk) disable iff (!rst)
        (cmdIssue == CmdAct) |-> (sincePre >= 5'(tRP)))
        else $error("ACT issued within tRP of PRE");

    // Column access waits out tRCD
    assert property (@(posedge clk) disable iff (!rst)
        (cmdIssue == CmdRd || cmdIssue == CmdWr) |-> (sinceAct >= 5'(tRCD)))
        else $error("RD or WR issued within tRCD of ACT");

endmodule

bind rankExec rankExecProps rankExecProps_inst (
    .clk(clk),
    .rst(rst),
    .cmdIssue(cmdIssue),
    .csN(csN)
);

// ==== rankExecTb.sv ====
module rankExecTb import rankPkg::*; ();

    localparam int NumRows  = 12;
    localparam int Watchdog = (NumRows * (tRFC + tWR + tRP + tRCD + 20) + 16) * 4;

    // One request row packed into a single table line
    typedef struct packed {
        logic    write;
        logic    miss;
        logic    empty;
        logic    autoPre;
        logic    refr;          // Raise refresh together with reqValid
        logic    bp;            // Random availability drops
        logic    imm;           // First command right after accept
        bankIdxT bank;
        rowT     row;
        colT     col;
        cmdT     c0;
        cmdT     c1;
        cmdT     c2;
    } stimT;

    logic    clk = 1'b0;
    logic    rst;
    logic    reqValid;
    logic    reqWrite;
    logic    reqPageMiss;
    logic    reqPageEmpty;
    logic    reqAutoPre;
    bankIdxT reqBank;
    rowT     reqRow;
    colT     reqCol;
    logic    refresh;
    logic    cmdAvailable;
    logic    dqAvailable;
    logic    idle;
    logic    csN;
    logic    actN;
    cmdAddrT pinA;
    bgT      bg;
    bkT      b;

    stimT  tbl [NumRows];
    string rowName [NumRows];
    int    rowLen [NumRows];        // Expected command count
    int    numRows;
    int    curIdx;
    string curName = "reset";
    int    cmdIdx;                  // Next expected command of the row
    bit    bpMode;
    int    cyc;                     // Rising edges seen
    int    acceptCyc;
    int    lastCyc;
    int    idleDue;
    int    refCyc;
    bit    refPending;
    int    apUntil [NumBanks];      // Earliest cycle a bank takes a command again
    int    valueErrs;
    int    timingErrs;
    cmdT   seen;

    rankExec rankExec_inst (
        .clk(clk), .rst(rst),
        .reqValid(reqValid), .reqWrite(reqWrite), .reqPageMiss(reqPageMiss),
        .reqPageEmpty(reqPageEmpty), .reqAutoPre(reqAutoPre),
        .reqBank(reqBank), .reqRow(reqRow), .reqCol(reqCol), .refresh(refresh),
        .cmdAvailable(cmdAvailable), .dqAvailable(dqAvailable),
        .idle(idle), .csN(csN), .actN(actN), .pinA(pinA), .bg(bg), .b(b)
    );

    always #2 clk = ~clk;

    // ----------------------------------------
    // Check helpers
    // ----------------------------------------
    task automatic addRow(input string name, input logic [6:0] flags, input bankIdxT bank,
                          input rowT row, input colT col, input cmdT c0, input cmdT c1,
                          input cmdT c2);
        tbl[numRows]     = {flags, bank, row, col, c0, c1, c2};
        rowName[numRows] = name;
        rowLen[numRows]  = (c0 != CmdNop) + (c1 != CmdNop) + (c2 != CmdNop);
        numRows++;
    endtask

    function automatic cmdT expectedCmd(input stimT s, input int k);
        if (k == 0) return s.c0;
        if (k == 1) return s.c1;
        return s.c2;
    endfunction

    // Pin pattern back to a command with Nop for anything unknown
    function automatic cmdT decodePins(input logic cs, input logic act, input logic [2:0] ctl);
        if (cs) return CmdNop;
        if (!act) return CmdAct;
        case (ctl)
            3'b010:  return CmdPre;
            3'b101:  return CmdRd;
            3'b100:  return CmdWr;
            3'b001:  return CmdRef;
            default: return CmdNop;
        endcase
    endfunction

    task automatic expectValue(input string what, input int expected, input int actual);
        assert (actual == expected) else begin
            $display("ERR %s %s: expected %0h, actual %0h", curName, what, expected, actual);
            valueErrs++;
        end
    endtask

    task automatic expectGap(input string what, input int expected, input int actual,
                             input logic exact);
        if (exact) begin
            assert (actual == expected) else begin
                $display("ERR %s %s: expected %0d, actual %0d", curName, what, expected, actual);
                timingErrs++;
            end
        end else begin
            assert (actual >= expected) else begin
                $display("ERR %s %s: expected at least %0d, actual %0d",
                         curName, what, expected, actual);
                timingErrs++;
            end
        end
    endtask

    task automatic checkPins(input cmdT cmd);
        stimT s;
        s = tbl[curIdx];
        expectValue("bank", (cmd == CmdRef) ? 0 : int'(s.bank), int'({bg, b}));
        case (cmd)
            CmdAct:        expectValue("row", int'(s.row), int'(pinA));     // A17..A15 low too
            CmdPre:        expectValue("A10 on PRE", 0, int'(pinA[10]));
            CmdRd, CmdWr: begin
                expectValue("column", int'(s.col), int'(pinA[9:0]));
                expectValue("A10 auto-precharge", int'(s.autoPre), int'(pinA[10]));
            end
            default: begin
            end
        endcase
    endtask

    task automatic checkCommand(input cmdT cmd);
        logic exact;
        exact = !tbl[curIdx].bp;    // Spacing is exact only without drops
        assert (cmdIdx < rowLen[curIdx]) else begin
            $display("%s: a command appeared after the expected sequence ended", curName);
            valueErrs++;
        end
        if (cmdIdx < rowLen[curIdx]) begin
            expectValue("command", int'(expectedCmd(tbl[curIdx], cmdIdx)), int'(cmd));
            assert (dqAvailable || !(cmd inside {CmdRd, CmdWr})) else begin
                $display("%s: column command issued while dqAvailable was low", curName);
                valueErrs++;
            end
            checkPins(cmd);
            if (cmdIdx == 0 && tbl[curIdx].imm) begin
                expectGap("accept to first command", 1, cyc - acceptCyc, 1'b1);
            end
            if (cmdIdx > 0 && cmd == CmdAct) begin
                expectGap("PRE to ACT", tRP, cyc - lastCyc, exact);
            end
            if (cmdIdx > 0 && (cmd == CmdRd || cmd == CmdWr)) begin
                expectGap("ACT to column", tRCD, cyc - lastCyc, exact);
            end
            if (cmd == CmdRef) begin
                for (int k = 0; k < NumBanks; k++) begin
                    expectGap("REF cycle vs bank release", apUntil[k], cyc, 1'b0);
                end
                refPending = 1'b1;
                refCyc     = cyc;
            end else begin
                expectGap("cycle vs bank release", apUntil[tbl[curIdx].bank], cyc, 1'b0);
            end
            if (cmd == CmdRd || cmd == CmdWr) begin
                idleDue = cyc + 1;
                if (tbl[curIdx].autoPre) begin
                    apUntil[tbl[curIdx].bank] = cyc + ((cmd == CmdWr) ? tWR + tRP : tRP);
                end
            end
            lastCyc = cyc;
            cmdIdx++;
        end
    endtask

    // ----------------------------------------
    // Pin monitor sampled on the rising edge
    // ----------------------------------------
    always @(posedge clk) begin
        cyc++;
        if (csN) begin
            expectValue("deselect actN", 1, int'(actN));    // Nop leaves the pins idle
            expectValue("deselect address and bank", 0, int'({pinA, bg, b}));
        end
        if (!rst) begin
            expectValue("csN in reset", 1, int'(csN));
        end else begin
            if (idle && (reqValid || refresh)) begin
                acceptCyc = cyc;
            end
            if (cyc == idleDue) begin
                expectValue("idle after column command", 1, int'(idle));
            end
            if (refPending && idle) begin
                expectGap("REF to idle", tRFC, cyc - refCyc, 1'b1);
                refPending = 1'b0;
            end
            assert (csN || cmdAvailable) else begin
                $display("%s: command issued while cmdAvailable was low", curName);
                valueErrs++;
            end
            seen = decodePins(csN, actN, pinA[16:14]);
            if (!csN) begin
                checkCommand(seen);
            end
        end
    end

    // Channel levels dropped at random in back-pressure rows
    always @(negedge clk) begin
        if (bpMode) begin
            cmdAvailable = ($urandom % 4) != 0;
            dqAvailable  = ($urandom % 4) != 0;
        end else begin
            cmdAvailable = 1'b1;
            dqAvailable  = 1'b1;
        end
    end

    initial begin
        #(Watchdog);
        $display("Timeout: the request table did not finish in time");
        $display("** FAIL **");
        $finish;
    end

    initial begin
        void'($urandom(32'hb26d));
        rst          = 1'b0;
        reqValid     = 1'b0;
        reqWrite     = 1'b0;
        reqPageMiss  = 1'b0;
        reqPageEmpty = 1'b0;
        reqAutoPre   = 1'b0;
        reqBank      = '0;
        reqRow       = '0;
        reqCol       = '0;
        refresh      = 1'b0;
        cmdAvailable = 1'b1;
        dqAvailable  = 1'b1;
        bpMode       = 1'b0;

        // Flag order write miss empty autoPre refresh backPressure immediate
        addRow("hitRd",          7'b0000001, 4'h3, 15'h0000, 10'h155, CmdRd,  CmdNop, CmdNop);
        addRow("hitWrAp",        7'b1001001, 4'h9, 15'h0000, 10'h2aa, CmdWr,  CmdNop, CmdNop);
        addRow("hitOtherBank",   7'b0000001, 4'h4, 15'h0000, 10'h0f0, CmdRd,  CmdNop, CmdNop);
        addRow("hitSameBank",    7'b1000000, 4'h9, 15'h0000, 10'h011, CmdWr,  CmdNop, CmdNop);
        addRow("missRd",         7'b0100001, 4'h6, 15'h1234, 10'h0c8, CmdPre, CmdAct, CmdRd);
        addRow("emptyWrAp",      7'b1011001, 4'hc, 15'h7abc, 10'h201, CmdAct, CmdWr,  CmdNop);
        addRow("refreshOverReq", 7'b0000100, 4'h2, 15'h0000, 10'h033, CmdRef, CmdNop, CmdNop);
        addRow("missWrBp",       7'b1100010, 4'h1, 15'h0421, 10'h3f0, CmdPre, CmdAct, CmdWr);
        addRow("emptyRdApBp",    7'b0011010, 4'hf, 15'h5555, 10'h07f, CmdAct, CmdRd,  CmdNop);
        addRow("hitWrApBp",      7'b1001010, 4'h7, 15'h0000, 10'h100, CmdWr,  CmdNop, CmdNop);
        addRow("refreshBp",      7'b0000110, 4'h0, 15'h0000, 10'h000, CmdRef, CmdNop, CmdNop);
        addRow("missRdAp",       7'b0101001, 4'hf, 15'h2aaa, 10'h3c3, CmdPre, CmdAct, CmdRd);

        repeat (16) @(negedge clk);
        expectValue("idle in reset", 0, int'(idle));
        rst = 1'b1;
        @(negedge clk);
        expectValue("idle after reset", 1, int'(idle));

        for (int i = 0; i < numRows; i++) begin
            while (!idle) @(negedge clk);
            curIdx       = i;
            curName      = rowName[i];
            cmdIdx       = 0;
            bpMode       = tbl[i].bp;
            reqWrite     = tbl[i].write;
            reqPageMiss  = tbl[i].miss;
            reqPageEmpty = tbl[i].empty;
            reqAutoPre   = tbl[i].autoPre;
            reqBank      = tbl[i].bank;
            reqRow       = tbl[i].row;
            reqCol       = tbl[i].col;
            refresh      = tbl[i].refr;
            reqValid     = 1'b1;            // Valid stays high in refresh rows too
            @(negedge clk);
            reqValid = 1'b0;
            refresh  = 1'b0;
            while (!(cmdIdx == rowLen[i] && idle)) @(negedge clk);
        end
        bpMode = 1'b0;
        repeat (4) @(negedge clk);

        $display("Errors: value %0d, timing %0d", valueErrs, timingErrs);
        if (valueErrs + timingErrs == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

// ==== files.f ====
rankPkg.sv
rowTimer.sv
bankBusyTracker.sv
ddrCmdEncoder.sv
rankCtrl.sv
rankExec.sv
rankExecProps.sv
rankExecTb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= rankExecTb
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only --timing --assert

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q '^\*\* PASS \*\*$$' $(LOG)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
